// ==== div_defs.svh ====
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// Divider operand width, even and at most half the bus word
`define DIV_WIDTH 16

// Iteration counter, wide enough to count DIV_WIDTH steps
`define DIV_CNT_W 5

// Wishbone data and byte address widths
`define WB_DW 32
`define WB_AW 4

// Word offsets in the byte address space
`define DIV_ADDR_OPER 4'h0 // Divisor and dividend, write starts a division
`define DIV_ADDR_STAT 4'h4 // Busy in bit 0, done in bit 1
`define DIV_ADDR_RES  4'h8 // Remainder and quotient

`endif

// ==== div_bus_pkg.sv ====
`include "div_defs.svh"

package div_bus_pkg;

    // Master to slave, held stable until ack
    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;  // High for a write
        logic [`WB_AW-1:0]  adr; // Byte address
        logic [`WB_DW-1:0]  dat; // Write data
    } wb_req_t;

    // Slave to master
    typedef struct packed {
        logic               ack; // One cycle per access
        logic [`WB_DW-1:0]  dat; // Read data, valid with ack
    } wb_rsp_t;

    // Operand word as written by the master
    typedef struct packed {
        logic [`WB_DW/2-1:0] divisor;  // Upper half
        logic [`WB_DW/2-1:0] dividend; // Lower half
    } div_oper_t;

    // Result word as read back
    typedef struct packed {
        logic [`WB_DW/2-1:0] remainder; // Upper half
        logic [`WB_DW/2-1:0] quotient;  // Lower half
    } div_res_t;

endpackage

// ==== div_ctrl_pkg.sv ====
`include "div_defs.svh"

package div_ctrl_pkg;

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE  = 3'd0, // Waiting for the first start
        LOAD  = 3'd1, // Operands into the datapath
        ITER  = 3'd2, // One shift-subtract step per cycle
        LATCH = 3'd3, // Result register update
        DONE  = 3'd4  // Result visible until the next start
    } div_state_e;

    // ALU step selection
    typedef enum logic {
        ALU_RESTORE = 1'b0, // Trial difference went negative
        ALU_SUB     = 1'b1  // Keep the difference
    } alu_op_e;

    // Datapath enables and selects, one bundle from the FSM
    typedef struct packed {
        logic    en_q;     // Dividend and quotient register
        logic    en_m;     // Divisor register
        logic    en_a;     // Partial remainder register
        logic    en_count; // Iteration counter increment
        logic    sel_q;    // 0 loads the dividend, 1 takes the ALU quotient
        logic    sel_a;    // 0 loads zero, 1 takes the ALU remainder
        logic    clear;    // Counter back to zero
        logic    en_out;   // Result register load
        alu_op_e alu_op;
    } dp_ctrl_t;

endpackage

// ==== div_alu.sv ====
`timescale 1ns/100ps
`include "div_defs.svh"

module div_alu (
    input  div_ctrl_pkg::alu_op_e  alu_op,
    input  logic [`DIV_WIDTH-1:0]  divisor,
    input  logic [`DIV_WIDTH:0]    partial_diff, // Shifted remainder minus divisor, sign in MSB
    input  logic [`DIV_WIDTH-1:0]  shifted_a,    // Remainder after the left shift
    input  logic [`DIV_WIDTH-1:0]  shifted_q,    // Quotient after the left shift, LSB empty
    output logic [`DIV_WIDTH-1:0]  a_next,
    output logic [`DIV_WIDTH-1:0]  q_next
);

    // One restoring step
    always_comb begin
        if (alu_op == div_ctrl_pkg::ALU_SUB) begin
            // Divisor fits, keep the difference
            a_next = shifted_a - divisor;             // Same low bits as partial_diff
            q_next = {shifted_q[`DIV_WIDTH-1:1], 1'b1};
        end else begin
            // Add the divisor back onto the trial difference
            a_next = partial_diff[`DIV_WIDTH-1:0] + divisor;
            q_next = {shifted_q[`DIV_WIDTH-1:1], 1'b0}; // Quotient bit stays clear
        end
    end

endmodule

// ==== div_datapath.sv ====
`timescale 1ns/100ps
`include "div_defs.svh"

module div_datapath (
    input  logic                    clk,
    input  logic                    rst_n,
    input  div_bus_pkg::div_oper_t  oper,       // Operands from the bus slave
    input  div_ctrl_pkg::dp_ctrl_t  ctrl,       // Enables and selects from the FSM
    input  logic                    en_final,   // Result visible on the output
    output logic                    count_done, // Last iteration in progress
    output logic                    sub_msb,    // Sign of the trial difference
    output div_bus_pkg::div_res_t   result
);

    logic [`DIV_WIDTH-1:0] m_q;          // Divisor
    logic [`DIV_WIDTH-1:0] q_q;          // Dividend shifting out, quotient shifting in
    logic [`DIV_WIDTH-1:0] a_q;          // Partial remainder
    logic [`DIV_CNT_W-1:0] count_q;
    logic [`DIV_WIDTH:0]   shifted_hi;   // Remainder with the next dividend bit, one bit wider
    logic [`DIV_WIDTH:0]   partial_diff;
    logic [`DIV_WIDTH-1:0] shifted_a;
    logic [`DIV_WIDTH-1:0] shifted_q;
    logic [`DIV_WIDTH-1:0] a_next;
    logic [`DIV_WIDTH-1:0] q_next;
    logic [`DIV_WIDTH-1:0] res_a_q;      // Latched remainder
    logic [`DIV_WIDTH-1:0] res_q_q;      // Latched quotient

    // Operand and working registers
    always_ff @(posedge clk) begin
        if (ctrl.en_m) begin
            m_q <= oper.divisor[`DIV_WIDTH-1:0];
        end
        if (ctrl.en_q) begin
            q_q <= ctrl.sel_q ? q_next : oper.dividend[`DIV_WIDTH-1:0];
        end
        if (ctrl.en_a) begin
            a_q <= ctrl.sel_a ? a_next : '0; // Remainder starts at zero
        end
    end

    // Iteration counter
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (ctrl.clear) begin
            count_q <= '0;
        end else if (ctrl.en_count) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign count_done = (count_q == `DIV_CNT_W'(`DIV_WIDTH - 1)); // Step DIV_WIDTH this cycle

    // Shift the A:Q pair left by one
    assign shifted_hi = {a_q, q_q[`DIV_WIDTH-1]};
    assign shifted_a  = shifted_hi[`DIV_WIDTH-1:0];
    assign shifted_q  = {q_q[`DIV_WIDTH-2:0], 1'b0};

    // Trial subtraction, one extra bit so the sign is never lost
    assign partial_diff = shifted_hi - {1'b0, m_q};
    assign sub_msb      = partial_diff[`DIV_WIDTH];

    div_alu i_alu (
        .alu_op       (ctrl.alu_op),
        .divisor      (m_q),
        .partial_diff (partial_diff),
        .shifted_a    (shifted_a),
        .shifted_q    (shifted_q),
        .a_next       (a_next),
        .q_next       (q_next)
    );

    // Result register, loaded once the last step has settled in A and Q
    always_ff @(posedge clk) begin
        if (ctrl.en_out) begin
            res_a_q <= a_q;
            res_q_q <= q_q;
        end
    end

    // Zero until the FSM reports the division finished
    always_comb begin
        result = '0;
        if (en_final) begin
            result.remainder[`DIV_WIDTH-1:0] = res_a_q;
            result.quotient[`DIV_WIDTH-1:0]  = res_q_q;
        end
    end

endmodule

// ==== div_controller.sv ====
`timescale 1ns/100ps
`include "div_defs.svh"

module div_controller (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,      // One cycle, from the bus slave
    input  logic                    count_done, // Last step this cycle
    input  logic                    sub_msb,    // Trial difference negative
    output div_ctrl_pkg::dp_ctrl_t  ctrl,
    output logic                    en_final,   // Result output enable
    output logic                    busy,
    output logic                    done
);

    div_ctrl_pkg::div_state_e state_q;
    div_ctrl_pkg::div_state_e state_d;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= div_ctrl_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // Next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            div_ctrl_pkg::IDLE: begin
                if (start) state_d = div_ctrl_pkg::LOAD;
            end
            div_ctrl_pkg::LOAD: begin
                state_d = div_ctrl_pkg::ITER;
            end
            div_ctrl_pkg::ITER: begin
                if (count_done) state_d = div_ctrl_pkg::LATCH; // Leave after step DIV_WIDTH
            end
            div_ctrl_pkg::LATCH: begin
                // Result register loads this cycle
                state_d = div_ctrl_pkg::DONE;
            end
            div_ctrl_pkg::DONE: begin
                if (start) state_d = div_ctrl_pkg::LOAD;
            end
            default: begin
                state_d = div_ctrl_pkg::IDLE;
            end
        endcase
    end

    // Datapath controls, decoded from the state
    always_comb begin
        ctrl = '0; // All enables off, ALU_RESTORE
        case (state_q)
            div_ctrl_pkg::LOAD: begin
                ctrl.clear = 1'b1;  // Counter to zero
                ctrl.en_m  = 1'b1;
                ctrl.en_q  = 1'b1;  // sel_q low picks the dividend
                ctrl.en_a  = 1'b1;  // sel_a low picks zero
            end
            div_ctrl_pkg::ITER: begin
                ctrl.en_a     = 1'b1;
                ctrl.en_q     = 1'b1;
                ctrl.en_count = 1'b1;
                ctrl.sel_a    = 1'b1;
                ctrl.sel_q    = 1'b1;
                // Negative trial difference means restore
                ctrl.alu_op   = sub_msb ? div_ctrl_pkg::ALU_RESTORE : div_ctrl_pkg::ALU_SUB;
            end
            div_ctrl_pkg::LATCH: begin
                ctrl.en_out = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

    // Status
    assign busy     = (state_q == div_ctrl_pkg::LOAD) || (state_q == div_ctrl_pkg::ITER);
    assign done     = (state_q == div_ctrl_pkg::LATCH) || (state_q == div_ctrl_pkg::DONE);
    assign en_final = (state_q == div_ctrl_pkg::DONE); // Result register settled one cycle after done

endmodule

// ==== div_wb_slave.sv ====
`timescale 1ns/100ps
`include "div_defs.svh"

module div_wb_slave (
    input  logic                    clk,
    input  logic                    rst_n,
    input  div_bus_pkg::wb_req_t    wb_req,
    output div_bus_pkg::wb_rsp_t    wb_rsp,
    input  logic                    busy,   // Division running
    input  logic                    done,   // Division finished
    input  div_bus_pkg::div_res_t   result,
    output logic                    start,  // High in the ack cycle of an accepted write
    output div_bus_pkg::div_oper_t  oper
);

    logic              ack_q;
    logic              start_q;
    logic              access;   // New access seen this cycle
    logic              is_oper;
    logic              is_stat;
    logic              is_res;
    logic [`WB_DW-1:0] rd_word;
    logic [`WB_DW-1:0] rdata_q;
    logic [`WB_DW-1:0] stat_word;
    div_bus_pkg::div_oper_t oper_q;

    // Only a fresh strobe counts, the ack cycle itself is not a new access
    assign access = wb_req.cyc && wb_req.stb && !ack_q;

    // Address decode
    assign is_oper = (wb_req.adr == `DIV_ADDR_OPER);
    assign is_stat = (wb_req.adr == `DIV_ADDR_STAT);
    assign is_res  = (wb_req.adr == `DIV_ADDR_RES);

    always_comb begin
        stat_word    = '0;
        stat_word[0] = busy;
        stat_word[1] = done;
    end

    // Read mux, unmapped offsets read as zero
    always_comb begin
        rd_word = '0;
        if (is_stat) begin
            rd_word = stat_word;
        end else if (is_res) begin
            rd_word = `WB_DW'(result); // Zero until done
        end
    end

    // Ack and start, one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack_q   <= 1'b0;
            start_q <= 1'b0;
        end else begin
            ack_q   <= access;
            start_q <= access && wb_req.we && is_oper && !busy; // Dropped while busy
        end
    end

    // Operand word and read data
    always_ff @(posedge clk) begin
        if (access && wb_req.we && is_oper && !busy) begin
            oper_q <= div_bus_pkg::div_oper_t'(wb_req.dat);
        end
        if (access) begin
            rdata_q <= wb_req.we ? '0 : rd_word;
        end
    end

    always_comb begin
        wb_rsp.ack = ack_q;
        wb_rsp.dat = rdata_q;
    end

    assign start = start_q;
    assign oper  = oper_q;

endmodule

// ==== div_top.sv ====
`timescale 1ns/100ps
`include "div_defs.svh"

module div_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  div_bus_pkg::wb_req_t  wb_req,
    output div_bus_pkg::wb_rsp_t  wb_rsp
);

    logic                   start;
    logic                   busy;
    logic                   done;
    logic                   en_final;
    logic                   count_done;
    logic                   sub_msb;
    div_bus_pkg::div_oper_t oper;
    div_bus_pkg::div_res_t  result;
    div_ctrl_pkg::dp_ctrl_t ctrl;

    // Bus side
    div_wb_slave i_wb_slave (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .busy   (busy),
        .done   (done),
        .result (result),
        .start  (start),
        .oper   (oper)
    );

    // Sequencing
    div_controller i_controller (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .count_done (count_done),
        .sub_msb    (sub_msb),
        .ctrl       (ctrl),
        .en_final   (en_final),
        .busy       (busy),
        .done       (done)
    );

    // Registers and shift-subtract step
    div_datapath i_datapath (
        .clk        (clk),
        .rst_n      (rst_n),
        .oper       (oper),
        .ctrl       (ctrl),
        .en_final   (en_final),
        .count_done (count_done),
        .sub_msb    (sub_msb),
        .result     (result)
    );

endmodule

// ==== div_assertions.sv ====
`timescale 1ns/100ps
`include "div_defs.svh"

module div_assertions (
    input logic                  clk,
    input logic                  rst_n,
    input div_bus_pkg::wb_req_t  wb_req,
    input div_bus_pkg::wb_rsp_t  wb_rsp,
    input logic                  start,
    input logic                  busy,
    input logic                  done
);

    // Ack answers a strobe seen one cycle earlier
    ack_after_stb: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
        else $error("ack without a strobe in the previous cycle");

    ack_single: assert property (@(posedge clk) disable iff (!rst_n)
        wb_rsp.ack |=> !wb_rsp.ack) // One cycle per access
        else $error("ack held for more than one cycle");

    busy_done_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(busy && done))
        else $error("busy and done high together");

    start_to_busy: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> busy)
        else $error("busy did not follow start");

    // LOAD, DIV_WIDTH steps, then LATCH raises done
    done_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(done) |-> $past(start, `DIV_WIDTH + 2))
        else $error("done rose at the wrong distance from start");

endmodule

bind div_top div_assertions i_assertions (
    .clk    (clk),
    .rst_n  (rst_n),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .start  (start),
    .busy   (busy),
    .done   (done)
);

// ==== tb_div_top.sv ====
`timescale 1ns/100ps
`include "div_defs.svh"

module tb_div_top;

    localparam int N_RANDOM = 40;
    localparam int N_EXTRA  = 4;  // Reset checks, busy write, result gating
    localparam int MAX_PAT  = 64;

    logic                  clk;
    logic                  rst_n;
    div_bus_pkg::wb_req_t  wb_req;
    div_bus_pkg::wb_rsp_t  wb_rsp;
    logic [`DIV_WIDTH:0]   pat_mem [0:4*MAX_PAT-1]; // MSB set marks an entry left unfilled
    int                    n_pat;
    int unsigned           cycle_cnt = 0;
    int unsigned           cycle_limit;

    div_top i_dut (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #20 clk = ~clk; // 40 ns period

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit) begin
            abort_run("Timeout, the run took more cycles than its tests allow");
        end
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("[FAIL] time %0t: %s got 0x%08h, expected 0x%08h",
                     $time, name, got, expected);
            $display("Simulation finished: FAIL");
            $fatal(1, "Value mismatch");
        end
    endtask

    // One classic cycle, inputs driven 2 ns after the edge, ack sampled mid cycle
    task automatic do_access(input logic we, input logic [`WB_AW-1:0] adr,
                             input logic [`WB_DW-1:0] wdata, output logic [`WB_DW-1:0] rdata);
        @(posedge clk);
        #2;
        wb_req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdata};
        while (!wb_rsp.ack) @(negedge clk);
        rdata = wb_rsp.dat;
        @(posedge clk);
        #2;
        wb_req = '0; // Strobe dropped after ack
        @(negedge clk);
        check_value("wb_rsp.ack after access", 32'(wb_rsp.ack), 32'd0);
    endtask

    task automatic write_word(input logic [`WB_AW-1:0] adr, input logic [`WB_DW-1:0] data);
        logic [`WB_DW-1:0] unused;
        do_access(1'b1, adr, data, unused);
    endtask

    task automatic read_word(input logic [`WB_AW-1:0] adr, output logic [`WB_DW-1:0] data);
        do_access(1'b0, adr, '0, data);
    endtask

    // Poll until done, then busy must be clear
    task automatic wait_done();
        logic [`WB_DW-1:0] stat;
        stat = '0;
        while (!stat[1]) begin
            read_word(`DIV_ADDR_STAT, stat);
        end
        check_value("status at done", stat, 32'h2);
    endtask

    // Restoring rule, a zero divisor gives all ones and keeps the dividend
    function automatic div_bus_pkg::div_res_t expected_result(
            input logic [`DIV_WIDTH-1:0] dividend, input logic [`DIV_WIDTH-1:0] divisor);
        div_bus_pkg::div_res_t r;
        r = '0;
        if (divisor == '0) begin
            r.quotient[`DIV_WIDTH-1:0]  = '1;
            r.remainder[`DIV_WIDTH-1:0] = dividend;
        end else begin
            r.quotient[`DIV_WIDTH-1:0]  = dividend / divisor;
            r.remainder[`DIV_WIDTH-1:0] = dividend % divisor;
        end
        return r;
    endfunction

    task automatic run_division(input logic [`DIV_WIDTH-1:0] dividend,
                               input logic [`DIV_WIDTH-1:0] divisor,
                               input div_bus_pkg::div_res_t exp_res);
        div_bus_pkg::div_oper_t oper;
        div_bus_pkg::div_res_t  res;
        logic [`WB_DW-1:0]      rdata;
        oper = '0;
        oper.dividend[`DIV_WIDTH-1:0] = dividend;
        oper.divisor[`DIV_WIDTH-1:0]  = divisor;
        write_word(`DIV_ADDR_OPER, oper); // Starts the division
        wait_done();
        read_word(`DIV_ADDR_RES, rdata);
        res = div_bus_pkg::div_res_t'(rdata);
        check_value("result.quotient", 32'(res.quotient), 32'(exp_res.quotient));
        check_value("result.remainder", 32'(res.remainder), 32'(exp_res.remainder));
    endtask

    initial begin
        div_bus_pkg::div_oper_t oper;
        div_bus_pkg::div_res_t  exp_res;
        logic [`WB_DW-1:0]      rdata;
        logic [`DIV_WIDTH-1:0]  dividend;
        logic [`DIV_WIDTH-1:0]  divisor;
        clk      = 1'b0;
        rst_n    = 1'b0;
        wb_req   = '0;
        n_pat    = 0;
        void'($urandom(32'hea59)); // Seeded once here
        for (int i = 0; i < 4 * MAX_PAT; i++) begin
            pat_mem[i] = {1'b1, `DIV_WIDTH'(i)};
        end
        $readmemh("div_patterns.txt", pat_mem);
        while (n_pat < MAX_PAT && !pat_mem[4*n_pat][`DIV_WIDTH]) n_pat++;
        if (n_pat == 0 || pat_mem[4*n_pat-1][`DIV_WIDTH]) begin
            abort_run("Pattern file is missing or has an incomplete vector");
        end
        cycle_limit = (n_pat + N_RANDOM + N_EXTRA) * (`DIV_WIDTH + 30);

        repeat (3) @(posedge clk);
        #2 rst_n = 1'b1;

        // Idle after reset, writes to read-only offsets change nothing
        read_word(`DIV_ADDR_STAT, rdata);
        check_value("status after reset", rdata, 32'd0);
        read_word(`DIV_ADDR_RES, rdata);
        check_value("result after reset", rdata, 32'd0);
        write_word(`DIV_ADDR_STAT, '1);
        write_word(`DIV_ADDR_RES, '1);
        read_word(`DIV_ADDR_STAT, rdata);
        check_value("status after ignored writes", rdata, 32'd0);

        for (int p = 0; p < n_pat; p++) begin
            exp_res = '0;
            exp_res.quotient[`DIV_WIDTH-1:0]  = pat_mem[4*p+2][`DIV_WIDTH-1:0];
            exp_res.remainder[`DIV_WIDTH-1:0] = pat_mem[4*p+3][`DIV_WIDTH-1:0];
            run_division(pat_mem[4*p][`DIV_WIDTH-1:0], pat_mem[4*p+1][`DIV_WIDTH-1:0], exp_res);
        end

        for (int r = 0; r < N_RANDOM; r++) begin
            dividend = `DIV_WIDTH'($urandom);
            divisor  = ($urandom % 4 == 0) ? `DIV_WIDTH'($urandom % 16) : `DIV_WIDTH'($urandom);
            run_division(dividend, divisor, expected_result(dividend, divisor));
        end

        // Second write while busy must be dropped
        oper = '0;
        oper.dividend[`DIV_WIDTH-1:0] = `DIV_WIDTH'(100);
        oper.divisor[`DIV_WIDTH-1:0]  = `DIV_WIDTH'(7);
        write_word(`DIV_ADDR_OPER, oper);
        read_word(`DIV_ADDR_STAT, rdata);
        check_value("status.busy", 32'(rdata[0]), 32'd1);
        oper.dividend[`DIV_WIDTH-1:0] = '1;
        oper.divisor[`DIV_WIDTH-1:0]  = `DIV_WIDTH'(3);
        write_word(`DIV_ADDR_OPER, oper);
        wait_done();
        read_word(`DIV_ADDR_RES, rdata);
        check_value("result after busy write", rdata,
                    expected_result(`DIV_WIDTH'(100), `DIV_WIDTH'(7)));

        // Result gated to zero during a new run
        oper.dividend[`DIV_WIDTH-1:0] = `DIV_WIDTH'(17);
        oper.divisor[`DIV_WIDTH-1:0]  = `DIV_WIDTH'(5);
        write_word(`DIV_ADDR_OPER, oper);
        read_word(`DIV_ADDR_RES, rdata);
        check_value("result while busy", rdata, 32'd0);
        read_word(`DIV_ADDR_STAT, rdata);
        check_value("status while busy", rdata, 32'h1);
        wait_done();
        read_word(`DIV_ADDR_RES, rdata);
        check_value("result of new run", rdata,
                    expected_result(`DIV_WIDTH'(17), `DIV_WIDTH'(5)));

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// ==== div_patterns.txt ====
// Directed divider vectors, one per line, all values in hex
// Columns: dividend divisor expected_quotient expected_remainder
0064 0007 000e 0002
ffff 0001 ffff 0000
0005 0009 0000 0005
0000 0003 0000 0000
1234 0000 ffff 1234
0000 0000 ffff 0000
ffff ffff 0001 0000
fffe ffff 0000 fffe
8000 0002 4000 0000
abcd 0010 0abc 000d
7fff 0100 007f 00ff
c350 00c8 00fa 0000
03e8 0003 014d 0001
ffff 00ff 0101 0000
8001 8000 0001 0001
00ff 0010 000f 000f
1000 1000 0001 0000
9c40 0007 1652 0002
ffff 8000 0001 7fff
0001 ffff 0000 0001
2710 0064 0064 0000
beef 0123 00a7 011a

// ==== tb.f ====
+incdir+.
div_bus_pkg.sv
div_ctrl_pkg.sv
div_alu.sv
div_datapath.sv
div_controller.sv
div_wb_slave.sv
div_top.sv
div_assertions.sv
tb_div_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the divider testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_div_top -f tb.f -o Vtb_div_top; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/Vtb_div_top; then
    echo "Simulation run returned a failing status"
    exit 1
fi

echo "Simulation run returned a passing status"
exit 0
